/* design/rv32i_pkg.sv */
package rv32i_pkg;

  localparam int XLEN              = 32;
  localparam int REG_AW            = 5;
  localparam int NUM_REGS          = 32;
  localparam int unsigned PC_STEP  = 4;   // Bytes per instruction

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

  localparam word_t RESET_PC = '0;

  typedef enum logic [6:0] {
    OP_LUI   = 7'b0110111,
    OP_JAL   = 7'b1101111,
    OP_JALR  = 7'b1100111,
    OP_BR    = 7'b1100011,
    OP_LOAD  = 7'b0000011,
    OP_STORE = 7'b0100011,
    OP_IMM   = 7'b0010011,
    OP_REG   = 7'b0110011
  } opcode_t;

  // funct3 of OP_IMM / OP_REG
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_WORD    = 3'b010;  // LW and SW
  localparam logic [2:0] F3_JALR    = 3'b000;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_t;

  // Encoded as the branch funct3
  typedef enum logic [2:0] {
    CMP_EQ  = 3'b000,
    CMP_NE  = 3'b001,
    CMP_LT  = 3'b100,
    CMP_GE  = 3'b101,
    CMP_LTU = 3'b110,
    CMP_GEU = 3'b111
  } cmp_op_t;

  typedef enum logic [1:0] {
    WB_ALU, WB_LOAD, WB_IMM, WB_PC4
  } wb_sel_t;

  // All zero is a bubble
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    is_branch;
    logic    is_jal;
    logic    is_jalr;
    logic    use_rs1;   // Operand A is rs1, else PC
    logic    use_imm;   // Operand B is the immediate, else rs2
    alu_op_t alu_op;
    cmp_op_t cmp_op;
    wb_sel_t wb_sel;
  } ctrl_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    pc;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    alu_res;
    word_t    store_data;
    word_t    imm;
    word_t    pc4;
    reg_idx_t rd;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    alu_res;
    word_t    load_data;
    word_t    imm;
    word_t    pc4;
    reg_idx_t rd;
  } mem_wb_t;

  // Register write value of a stage, picked by wb_sel
  function automatic word_t wb_value(wb_sel_t sel, word_t alu_res, word_t load_data,
                                     word_t imm, word_t pc4);
    case (sel)
      WB_LOAD: return load_data;
      WB_IMM:  return imm;
      WB_PC4:  return pc4;
      default: return alu_res;
    endcase
  endfunction

endpackage

/* design/rv32i_decode.sv */
`timescale 1ns/10ps

module rv32i_decode
  import rv32i_pkg::*;
(
  input  word_t    i_instr,
  output ctrl_t    o_ctrl,
  output word_t    o_imm,
  output reg_idx_t o_rs1,
  output reg_idx_t o_rs2,
  output reg_idx_t o_rd
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_t    arith_op;
  logic       arith_ok;
  logic       is_reg;
  logic       alt;

  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];
  assign o_rs1  = i_instr[19:15];
  assign o_rs2  = i_instr[24:20];
  assign o_rd   = i_instr[11:7];

  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'b0};
  assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};

  // ALU op shared by register and immediate forms
  always_comb begin
    is_reg   = (i_instr[6:0] == OP_REG);
    alt      = (funct7 == F7_ALT);
    arith_op = ALU_ADD;
    case (funct3)
      F3_ADD_SUB: arith_op = (is_reg && alt) ? ALU_SUB : ALU_ADD;  // No SUBI
      F3_SLL:     arith_op = ALU_SLL;
      F3_SLT:     arith_op = ALU_SLT;
      F3_SLTU:    arith_op = ALU_SLTU;
      F3_XOR:     arith_op = ALU_XOR;
      F3_SRL_SRA: arith_op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      arith_op = ALU_OR;
      F3_AND:     arith_op = ALU_AND;
      default:    arith_op = ALU_ADD;
    endcase
    // Immediates only check funct7 on shifts
    arith_ok = (funct7 == F7_BASE) || (alt && (funct3 == F3_SRL_SRA ||
               (is_reg && funct3 == F3_ADD_SUB))) ||
               (!is_reg && funct3 != F3_SLL && funct3 != F3_SRL_SRA);
  end

  always_comb begin
    o_ctrl = '0;
    o_imm  = '0;
    case (i_instr[6:0])
      OP_LUI: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.wb_sel    = WB_IMM;
        o_imm            = imm_u;
      end
      OP_JAL: begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.is_jal    = 1'b1;
        o_ctrl.use_imm   = 1'b1;   // PC + imm
        o_ctrl.wb_sel    = WB_PC4;
        o_imm            = imm_j;
      end
      OP_JALR: begin
        if (funct3 == F3_JALR) begin
          o_ctrl.reg_write = 1'b1;
          o_ctrl.is_jalr   = 1'b1;
          o_ctrl.use_rs1   = 1'b1;
          o_ctrl.use_imm   = 1'b1;
          o_ctrl.wb_sel    = WB_PC4;
          o_imm            = imm_i;
        end
      end
      OP_BR: begin
        if (funct3[2:1] != 2'b01) begin  // 010 and 011 undefined
          o_ctrl.is_branch = 1'b1;
          o_ctrl.use_imm   = 1'b1;  // ALU forms the target
          o_ctrl.cmp_op    = cmp_op_t'(funct3);
          o_imm            = imm_b;
        end
      end
      OP_LOAD: begin
        if (funct3 == F3_WORD) begin
          o_ctrl.reg_write = 1'b1;
          o_ctrl.mem_read  = 1'b1;
          o_ctrl.use_rs1   = 1'b1;
          o_ctrl.use_imm   = 1'b1;
          o_ctrl.wb_sel    = WB_LOAD;
          o_imm            = imm_i;
        end
      end
      OP_STORE: begin
        if (funct3 == F3_WORD) begin
          o_ctrl.mem_write = 1'b1;
          o_ctrl.use_rs1   = 1'b1;
          o_ctrl.use_imm   = 1'b1;
          o_imm            = imm_s;
        end
      end
      OP_IMM, OP_REG: begin
        if (arith_ok) begin
          o_ctrl.reg_write = 1'b1;
          o_ctrl.use_rs1   = 1'b1;
          o_ctrl.use_imm   = !is_reg;
          o_ctrl.alu_op    = arith_op;
          o_imm            = imm_i;
        end
      end
      default: ;  // Bubble
    endcase
  end

endmodule

/* design/rv32i_regfile.sv */
`timescale 1ns/10ps

module rv32i_regfile
  import rv32i_pkg::*;
(
  input  logic     clk,
  input  logic     i_arst_n,
  input  logic     i_we,
  input  reg_idx_t i_wr_idx,
  input  word_t    i_wr_data,
  input  reg_idx_t i_rd_idx_a,
  input  reg_idx_t i_rd_idx_b,
  output word_t    o_rd_a,
  output word_t    o_rd_b
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
    end else if (i_we && i_wr_idx != '0) begin
      regs[i_wr_idx] <= i_wr_data;
    end
  end

  // Write-through so ID sees the WB result in the same cycle
  function automatic word_t read_port(reg_idx_t idx);
    if (idx == '0) return '0;
    if (i_we && idx == i_wr_idx) return i_wr_data;
    return regs[idx];
  endfunction

  always_comb begin
    o_rd_a = read_port(i_rd_idx_a);
    o_rd_b = read_port(i_rd_idx_b);
  end

endmodule

/* design/rv32i_pipe_reg.sv */
`timescale 1ns/10ps

module rv32i_pipe_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_load,
  input  logic i_flush,
  input  T     i_d,
  output T     o_q
);

  // Zero payload carries a zero control word, i.e. a bubble
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_q <= '0;
    end else if (i_flush) begin
      o_q <= '0;
    end else if (i_load) begin
      o_q <= i_d;
    end
  end

endmodule

/* design/rv32i_execute.sv */
`timescale 1ns/10ps

module rv32i_execute
  import rv32i_pkg::*;
(
  input  id_ex_t  i_id_ex,
  input  ex_mem_t i_ex_mem,
  input  mem_wb_t i_mem_wb,
  output ex_mem_t o_ex_mem,
  output logic    o_redirect,
  output word_t   o_target,
  output logic    o_load_use
);

  ctrl_t ctrl;
  word_t mem_fwd, wb_fwd;
  word_t rs1_val, rs2_val;
  word_t op_a, op_b;
  word_t alu_res;
  logic  taken;
  logic  rs1_used, rs2_used;

  assign ctrl = i_id_ex.ctrl;

  always_comb begin
    case (i_ex_mem.ctrl.wb_sel)
      WB_IMM:  mem_fwd = i_ex_mem.imm;
      WB_PC4:  mem_fwd = i_ex_mem.pc4;
      default: mem_fwd = i_ex_mem.alu_res;  // No load data yet in MEM
    endcase
  end

  assign wb_fwd  = wb_value(i_mem_wb.ctrl.wb_sel, i_mem_wb.alu_res, i_mem_wb.load_data,
                            i_mem_wb.imm, i_mem_wb.pc4);

  // Youngest producer wins
  function automatic word_t fwd_operand(reg_idx_t idx, word_t reg_val);
    if (idx == '0) return reg_val;
    if (i_ex_mem.ctrl.reg_write && i_ex_mem.rd == idx) return mem_fwd;
    if (i_mem_wb.ctrl.reg_write && i_mem_wb.rd == idx) return wb_fwd;
    return reg_val;
  endfunction

  always_comb begin
    rs1_val = fwd_operand(i_id_ex.rs1, i_id_ex.rs1_val);
    rs2_val = fwd_operand(i_id_ex.rs2, i_id_ex.rs2_val);
  end

  assign op_a = ctrl.use_rs1 ? rs1_val : i_id_ex.pc;
  assign op_b = ctrl.use_imm ? i_id_ex.imm : rs2_val;

  always_comb begin
    case (ctrl.alu_op)
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_AND:  alu_res = op_a & op_b;
      ALU_OR:   alu_res = op_a | op_b;
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_SLL:  alu_res = op_a << op_b[4:0];
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      default:  alu_res = op_a + op_b;
    endcase
  end

  always_comb begin
    case (ctrl.cmp_op)
      CMP_EQ:  taken = (rs1_val == rs2_val);
      CMP_NE:  taken = (rs1_val != rs2_val);
      CMP_LT:  taken = ($signed(rs1_val) < $signed(rs2_val));
      CMP_GE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      CMP_LTU: taken = (rs1_val < rs2_val);
      CMP_GEU: taken = (rs1_val >= rs2_val);
      default: taken = 1'b0;
    endcase
  end

  assign o_redirect = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && taken);
  assign o_target   = {alu_res[XLEN-1:1], 1'b0};  // Clears bit 0 for JALR

  // Operands actually read by this instruction
  assign rs1_used = ctrl.use_rs1 || ctrl.is_branch;
  assign rs2_used = (ctrl.use_rs1 && !ctrl.use_imm) || ctrl.is_branch || ctrl.mem_write;

  assign o_load_use = i_ex_mem.ctrl.mem_read && i_ex_mem.rd != '0 &&
                      ((rs1_used && i_ex_mem.rd == i_id_ex.rs1) ||
                       (rs2_used && i_ex_mem.rd == i_id_ex.rs2));

  always_comb begin
    o_ex_mem.ctrl       = ctrl;
    o_ex_mem.alu_res    = alu_res;
    o_ex_mem.store_data = rs2_val;
    o_ex_mem.imm        = i_id_ex.imm;
    o_ex_mem.pc4        = i_id_ex.pc + PC_STEP;  // Link value
    o_ex_mem.rd         = i_id_ex.rd;
  end

endmodule

/* design/rv32i_hazard.sv */
`timescale 1ns/10ps

module rv32i_hazard (
  input  logic i_load_use,
  input  logic i_redirect,
  input  logic i_imem_resp,
  input  logic i_dmem_resp,
  input  logic i_dmem_busy,
  output logic o_load_pc,
  output logic o_load_if,
  output logic o_load_id,
  output logic o_load_ex,
  output logic o_load_mem,
  output logic o_flush_if,
  output logic o_flush_id,
  output logic o_flush_ex
);

  logic mem_wait;

  assign mem_wait = !i_imem_resp || (i_dmem_busy && !i_dmem_resp);

  always_comb begin
    o_load_pc  = 1'b1;
    o_load_if  = 1'b1;
    o_load_id  = 1'b1;
    o_load_ex  = 1'b1;
    o_load_mem = 1'b1;
    o_flush_if = 1'b0;
    o_flush_id = 1'b0;
    o_flush_ex = 1'b0;

    if (mem_wait) begin         // Whole pipe holds
      o_load_pc  = 1'b0;
      o_load_if  = 1'b0;
      o_load_id  = 1'b0;
      o_load_ex  = 1'b0;
      o_load_mem = 1'b0;
    end else if (i_load_use) begin
      // ID/EX stays loaded, it recirculates its own instruction
      o_load_pc  = 1'b0;
      o_load_if  = 1'b0;
      o_load_ex  = 1'b0;
      o_flush_ex = 1'b1;        // Bubble into MEM
    end else if (i_redirect) begin
      o_flush_if = 1'b1;        // Two wrong-path slots
      o_flush_id = 1'b1;
    end
  end

endmodule

/* design/rv32i_core.sv */
`timescale 1ns/10ps

module rv32i_core
  import rv32i_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,
  output word_t o_imem_addr,
  output logic  o_imem_read,
  input  word_t i_imem_data,
  input  logic  i_imem_resp,
  output word_t o_dmem_addr,
  output word_t o_dmem_wdata,
  output logic  o_dmem_read,
  output logic  o_dmem_write,
  input  word_t i_dmem_rdata,
  input  logic  i_dmem_resp
);

  word_t    pc;
  word_t    if_id_pc, if_id_instr;
  ctrl_t    id_ctrl;
  word_t    id_imm;
  reg_idx_t id_rs1, id_rs2, id_rd;
  reg_idx_t rf_idx_a, rf_idx_b;
  word_t    rf_a, rf_b;
  word_t    wb_data;
  id_ex_t   id_ex_d, id_ex_q;
  ex_mem_t  ex_mem_d, ex_mem_q;
  mem_wb_t  mem_wb_d, mem_wb_q;
  logic     redirect, load_use, dmem_busy;
  word_t    target;
  logic     load_pc, load_if, load_id, load_ex, load_mem;
  logic     flush_if, flush_id, flush_ex;
  logic     dmem_done;
  word_t    rdata_hold;

  // IF
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc <= RESET_PC;
    end else if (load_pc) begin
      pc <= redirect ? target : pc + PC_STEP;
    end
  end

  assign o_imem_addr = pc;
  assign o_imem_read = 1'b1;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      if_id_pc    <= '0;
      if_id_instr <= '0;        // Zero word decodes to a bubble
    end else if (flush_if) begin
      if_id_pc    <= '0;
      if_id_instr <= '0;
    end else if (load_if) begin
      if_id_pc    <= pc;
      if_id_instr <= i_imem_data;
    end
  end

  // ID
  rv32i_decode u_decode (
    .i_instr (if_id_instr),
    .o_ctrl  (id_ctrl),
    .o_imm   (id_imm),
    .o_rs1   (id_rs1),
    .o_rs2   (id_rs2),
    .o_rd    (id_rd)
  );

  // During a load-use stall the EX operands are re-read, picking up the WB write
  assign rf_idx_a = load_use ? id_ex_q.rs1 : id_rs1;
  assign rf_idx_b = load_use ? id_ex_q.rs2 : id_rs2;

  rv32i_regfile u_regfile (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_we       (mem_wb_q.ctrl.reg_write),
    .i_wr_idx   (mem_wb_q.rd),
    .i_wr_data  (wb_data),
    .i_rd_idx_a (rf_idx_a),
    .i_rd_idx_b (rf_idx_b),
    .o_rd_a     (rf_a),
    .o_rd_b     (rf_b)
  );

  always_comb begin
    if (load_use) begin
      id_ex_d         = id_ex_q;   // Same instruction, fresh operands
      id_ex_d.rs1_val = rf_a;
      id_ex_d.rs2_val = rf_b;
    end else begin
      id_ex_d.ctrl    = id_ctrl;
      id_ex_d.pc      = if_id_pc;
      id_ex_d.rs1_val = rf_a;
      id_ex_d.rs2_val = rf_b;
      id_ex_d.imm     = id_imm;
      id_ex_d.rs1     = id_rs1;
      id_ex_d.rs2     = id_rs2;
      id_ex_d.rd      = id_rd;
    end
  end

  rv32i_pipe_reg #(.T(id_ex_t)) u_id_ex (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_load   (load_id),
    .i_flush  (flush_id),
    .i_d      (id_ex_d),
    .o_q      (id_ex_q)
  );

  // EX, regfile feeds it directly
  rv32i_execute u_execute (
    .i_id_ex    (id_ex_q),
    .i_ex_mem   (ex_mem_q),
    .i_mem_wb   (mem_wb_q),
    .o_ex_mem   (ex_mem_d),
    .o_redirect (redirect),
    .o_target   (target),
    .o_load_use (load_use)
  );

  rv32i_pipe_reg #(.T(ex_mem_t)) u_ex_mem (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_load   (load_ex),
    .i_flush  (flush_ex),
    .i_d      (ex_mem_d),
    .o_q      (ex_mem_q)
  );

  // MEM
  // Access finished under a fetch wait, strobes stay low until EX/MEM moves on
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dmem_done  <= 1'b0;
      rdata_hold <= '0;
    end else if (load_mem) begin
      dmem_done  <= 1'b0;
    end else if (dmem_busy && i_dmem_resp) begin
      dmem_done  <= 1'b1;
      rdata_hold <= i_dmem_rdata;
    end
  end

  assign o_dmem_addr  = {ex_mem_q.alu_res[XLEN-1:2], 2'b00};
  assign o_dmem_wdata = ex_mem_q.store_data;
  assign o_dmem_read  = ex_mem_q.ctrl.mem_read && !dmem_done;
  assign o_dmem_write = ex_mem_q.ctrl.mem_write && !dmem_done;
  assign dmem_busy    = o_dmem_read || o_dmem_write;

  always_comb begin
    mem_wb_d.ctrl      = ex_mem_q.ctrl;
    mem_wb_d.alu_res   = ex_mem_q.alu_res;
    mem_wb_d.load_data = dmem_done ? rdata_hold : i_dmem_rdata;
    mem_wb_d.imm       = ex_mem_q.imm;
    mem_wb_d.pc4       = ex_mem_q.pc4;
    mem_wb_d.rd        = ex_mem_q.rd;
  end

  rv32i_pipe_reg #(.T(mem_wb_t)) u_mem_wb (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_load   (load_mem),
    .i_flush  (1'b0),
    .i_d      (mem_wb_d),
    .o_q      (mem_wb_q)
  );

  // WB
  assign wb_data = wb_value(mem_wb_q.ctrl.wb_sel, mem_wb_q.alu_res, mem_wb_q.load_data,
                            mem_wb_q.imm, mem_wb_q.pc4);

  rv32i_hazard u_hazard (
    .i_load_use  (load_use),
    .i_redirect  (redirect),
    .i_imem_resp (i_imem_resp),
    .i_dmem_resp (i_dmem_resp),
    .i_dmem_busy (dmem_busy),
    .o_load_pc   (load_pc),
    .o_load_if   (load_if),
    .o_load_id   (load_id),
    .o_load_ex   (load_ex),
    .o_load_mem  (load_mem),
    .o_flush_if  (flush_if),
    .o_flush_id  (flush_id),
    .o_flush_ex  (flush_ex)
  );

endmodule

/* dv/rv32i_core_checker.sv */
`timescale 1ns/10ps

module rv32i_core_checker
  import rv32i_pkg::*;
(
  input logic  clk,
  input logic  i_arst_n,
  input logic  o_dmem_read,
  input logic  o_dmem_write,
  input logic  i_imem_resp,
  input word_t o_dmem_addr,
  input word_t o_imem_addr
);

  // Pipeline comes out of reset empty
  a_idle_after_reset: assert property (@(posedge clk)
    $rose(i_arst_n) |-> !o_dmem_read && !o_dmem_write)
    else $error("data strobe high in first cycle after reset");

  a_no_read_write: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(o_dmem_read && o_dmem_write))
    else $error("data read and write strobes high together");

  a_word_aligned: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_dmem_addr[1:0] == 2'b00)
    else $error("data address not word aligned");

  // Fetch address holds through a wait
  a_imem_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    !i_imem_resp |=> $stable(o_imem_addr))
    else $error("fetch address moved while imem response was low");

endmodule

/* dv/rv32i_core_tb.sv */
`timescale 1ns/10ps

module rv32i_core_tb
  import rv32i_pkg::*;
();

  localparam int    CLK_PERIOD = 20;
  localparam int    MEM_WORDS  = 1024;
  localparam word_t SENT_ADDR  = 32'h0000_07FC;  // Final store of the program
  localparam word_t POISON     = 32'hDEAD_BEEF;  // Bus value with no valid data

  logic  clk        = 1'b0;
  logic  arst_n     = 1'b0;
  logic  imem_resp  = 1'b1;
  logic  dmem_resp  = 1'b1;
  word_t imem_data  = '0;
  word_t dmem_rdata = '0;
  word_t imem_addr, dmem_addr, dmem_wdata;
  logic  imem_read, dmem_read, dmem_write;

  word_t imem [MEM_WORDS];
  word_t dmem [MEM_WORDS];
  word_t exp_addr[$], exp_data[$];
  word_t got_addr[$], got_data[$];
  int    prog_len      = 0;
  int    errors        = 0;
  int    store_idx     = 0;
  bit    program_ready = 1'b0;
  bit    random_wait   = 1'b0;
  bit    phase_active  = 1'b0;
  bit    phase_done    = 1'b0;

  always #(CLK_PERIOD/2) clk = ~clk;

  rv32i_core UUT (
    .clk          (clk),
    .i_arst_n     (arst_n),
    .o_imem_addr  (imem_addr),
    .o_imem_read  (imem_read),
    .i_imem_data  (imem_data),
    .i_imem_resp  (imem_resp),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_read  (dmem_read),
    .o_dmem_write (dmem_write),
    .i_dmem_rdata (dmem_rdata),
    .i_dmem_resp  (dmem_resp)
  );

  bind rv32i_core rv32i_core_checker u_checker (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .o_dmem_read  (o_dmem_read),
    .o_dmem_write (o_dmem_write),
    .i_imem_resp  (i_imem_resp),
    .o_dmem_addr  (o_dmem_addr),
    .o_imem_addr  (o_imem_addr)
  );

  // Instruction encoders
  function automatic word_t r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic word_t i_type(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
    return {12'(imm), 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic word_t s_type(int imm, int rs2, int rs1);
    logic [11:0] im;
    im = 12'(imm);
    return {im[11:5], 5'(rs2), 5'(rs1), 3'b010, im[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(int imm, int rs2, int rs1, logic [2:0] f3);
    logic [12:0] im;
    im = 13'(imm);
    return {im[12], im[10:5], 5'(rs2), 5'(rs1), f3, im[4:1], im[11], 7'b1100011};
  endfunction

  function automatic word_t u_type(int imm20, int rd);
    return {20'(imm20), 5'(rd), 7'b0110111};
  endfunction

  function automatic word_t j_type(int imm, int rd);
    logic [20:0] im;
    im = 21'(imm);
    return {im[20], im[10:1], im[11], im[19:12], 5'(rd), 7'b1101111};
  endfunction

  function automatic int rnd12();
    return int'($urandom_range(4095)) - 2048;
  endfunction

  // Initial data memory content
  function automatic word_t fill_word(int i);
    return word_t'(i) * 32'h9E37_79B1 ^ 32'h5A5A_0000;
  endfunction

  task automatic emit(word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic build_program();
    logic [2:0] conds [6];
    int         p;
    int         k;
    conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    for (int i = 0; i < MEM_WORDS; i++) imem[i] = '0;
    // Seed operands, then a chain using the last two results
    emit(u_type(int'($urandom_range(20'hFFFFF)), 1));
    emit(i_type(rnd12(), 1, F3_ADD_SUB, 1, OP_IMM));
    emit(i_type(rnd12(), 0, F3_ADD_SUB, 2, OP_IMM));
    emit(r_type(F7_BASE, 1, 2, F3_ADD_SUB, 3));
    emit(r_type(F7_ALT, 2, 3, F3_ADD_SUB, 4));
    emit(r_type(F7_BASE, 3, 4, F3_XOR, 5));
    emit(r_type(F7_BASE, 4, 5, F3_OR, 6));
    emit(r_type(F7_BASE, 5, 6, F3_AND, 7));
    emit(r_type(F7_BASE, 6, 7, F3_SLT, 8));
    emit(r_type(F7_BASE, 7, 6, F3_SLTU, 9));
    emit(r_type(F7_BASE, 5, 7, F3_SLL, 10));
    emit(r_type(F7_BASE, 7, 10, F3_SRL_SRA, 11));
    emit(r_type(F7_ALT, 5, 4, F3_SRL_SRA, 12));
    emit(i_type(rnd12(), 12, F3_XOR, 13, OP_IMM));
    emit(i_type(rnd12(), 13, F3_OR, 14, OP_IMM));
    emit(i_type(rnd12(), 14, F3_AND, 15, OP_IMM));
    emit(i_type(rnd12(), 13, F3_SLT, 16, OP_IMM));
    emit(i_type(rnd12(), 13, F3_SLTU, 17, OP_IMM));
    emit(i_type(int'($urandom_range(31)), 14, F3_SLL, 18, OP_IMM));
    emit(i_type(int'($urandom_range(31)), 18, F3_SRL_SRA, 19, OP_IMM));
    emit(i_type(1024 + int'($urandom_range(31)), 4, F3_SRL_SRA, 30, OP_IMM));
    for (int r = 3; r <= 19; r++) emit(s_type(256 + 4 * (r - 3), r, 0));
    emit(s_type(256 + 68, 30, 0));
    // Load followed by its consumer
    emit(s_type(512, 3, 0));
    emit(i_type(512, 0, F3_WORD, 21, OP_LOAD));
    emit(r_type(F7_BASE, 4, 21, F3_ADD_SUB, 22));
    emit(s_type(516, 22, 0));
    emit(i_type(512, 0, F3_WORD, 23, OP_LOAD));
    emit(s_type(520, 23, 0));
    // Branches: negative x24, positive x25
    emit(u_type(int'($urandom_range(20'h7FFFF)) + 32'h80000, 24));
    emit(i_type(rnd12(), 24, F3_ADD_SUB, 24, OP_IMM));
    emit(i_type(int'($urandom_range(1, 2047)), 0, F3_ADD_SUB, 25, OP_IMM));
    k = 0;
    for (int c = 0; c < 6; c++) begin
      emit(b_type(8, 25, 24, conds[c]));  // Taken skips the marker
      emit(s_type(768 + 4 * k, 24, 0));
      emit(b_type(8, 24, 25, conds[c]));
      emit(s_type(772 + 4 * k, 25, 0));
      emit(b_type(8, 24, 24, conds[c]));
      emit(s_type(776 + 4 * k, 24, 0));
      k += 3;
    end
    // JAL over two markers
    emit(j_type(12, 27));
    emit(s_type(1024, 24, 0));
    emit(s_type(1028, 24, 0));
    emit(s_type(1032, 27, 0));
    // JALR to an odd address
    p = prog_len;
    emit(i_type(4 * (p + 3) + 1, 0, F3_ADD_SUB, 28, OP_IMM));
    emit(i_type(0, 28, F3_JALR, 29, OP_JALR));
    emit(s_type(1036, 24, 0));
    emit(s_type(1040, 29, 0));
    // x0 stays zero, LUI value
    emit(i_type(rnd12(), 0, F3_ADD_SUB, 0, OP_IMM));
    emit(r_type(F7_BASE, 2, 1, F3_ADD_SUB, 0));
    emit(s_type(1280, 0, 0));
    emit(u_type(int'($urandom_range(20'hFFFFF)), 31));
    emit(s_type(1284, 31, 0));
    emit(i_type(12'h5A5, 0, F3_ADD_SUB, 31, OP_IMM));
    emit(s_type(int'(SENT_ADDR), 31, 0));
    emit(j_type(0, 0));                   // Park here
  endtask

  function automatic word_t alu_ref(logic [2:0] f3, bit alt, word_t x, word_t y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return {31'b0, $signed(x) < $signed(y)};
      3'b011:  return {31'b0, x < y};
      3'b100:  return x ^ y;
      3'b101:  return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  // Architectural run of the program, records the expected stores
  function automatic void run_model();
    word_t      regs [32];
    word_t      mem [MEM_WORDS];
    word_t      pc, nxt, ins, a, b, imm_i, res, addr;
    logic [2:0] f3;
    bit         wr, taken, done;
    int         steps;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(i);
    pc    = RESET_PC;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 10000) begin
      ins   = imem[pc[11:2]];
      f3    = ins[14:12];
      a     = regs[ins[19:15]];
      b     = regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      nxt   = pc + 4;
      res   = '0;
      wr    = 1'b1;
      case (ins[6:0])
        7'b0110111: res = {ins[31:12], 12'b0};
        7'b1101111: begin
          res = pc + 4;
          nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        7'b1100111: begin
          res = pc + 4;
          nxt = (a + imm_i) & ~32'h1;
        end
        7'b1100011: begin
          wr = 1'b0;
          case (f3)
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            3'b101:  taken = ($signed(a) >= $signed(b));
            3'b110:  taken = (a < b);
            default: taken = (a >= b);
          endcase
          if (taken) nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        7'b0000011: res = mem[(a + imm_i) >> 2];
        7'b0100011: begin
          wr   = 1'b0;
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          mem[addr[11:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
          done = (addr == SENT_ADDR);
        end
        7'b0010011: res = alu_ref(f3, f3 == 3'b101 && ins[30], a, imm_i);
        7'b0110011: res = alu_ref(f3, ins[30], a, b);
        default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
      pc = nxt;
      steps++;
    end
  endfunction

  task automatic compare_addr(word_t got, word_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR o_dmem_addr got %h exp %h (store %0d)", got, exp, store_idx);
      $display("Finished with errors");
      $fatal(1, "store address mismatch");
    end
  endtask

  task automatic compare_data(word_t got, word_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR o_dmem_wdata got %h exp %h (store %0d)", got, exp, store_idx);
      $display("Finished with errors");
      $fatal(1, "store data mismatch");
    end
  endtask

  // Memory responses and store capture
  always @(negedge clk) begin
    if (!arst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) dmem[i] = fill_word(i);
    end
    if (random_wait) begin
      imem_resp = ($urandom_range(99) >= 30);
      dmem_resp = ($urandom_range(99) >= 30);
    end else begin
      imem_resp = 1'b1;
      dmem_resp = 1'b1;
    end
    // Data only for a strobed access that responds this cycle
    imem_data  = (imem_read && imem_resp) ? imem[imem_addr[11:2]] : POISON;
    dmem_rdata = (dmem_read && dmem_resp) ? dmem[dmem_addr[11:2]] : POISON;
    if (phase_active && dmem_write && dmem_resp) begin  // Completes at next rising edge
      dmem[dmem_addr[11:2]] = dmem_wdata;
      got_addr.push_back(dmem_addr);
      got_data.push_back(dmem_wdata);
    end
  end

  always @(posedge clk) begin : compare_stores
    word_t a;
    word_t d;
    if (!arst_n) begin
      store_idx  = 0;
      phase_done = 1'b0;
    end else if (got_addr.size() > 0) begin
      a = got_addr.pop_front();
      d = got_data.pop_front();
      if (store_idx >= exp_addr.size()) begin
        errors++;
        $display("Extra store to %h after the expected sequence ended", a);
        $display("Finished with errors");
        $fatal(1, "unexpected store");
      end else begin
        compare_addr(a, exp_addr[store_idx]);
        compare_data(d, exp_data[store_idx]);
        if (store_idx == exp_addr.size() - 1) phase_done = 1'b1;
        store_idx++;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (program_ready);
    limit = 2 * prog_len * 10 + 20;       // Two phases plus resets
    #(limit * CLK_PERIOD);
    $display("Timed out before the final store, stores are missing or the core hung");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(96580));
    build_program();
    run_model();
    program_ready = 1'b1;
    for (int ph = 0; ph < 2; ph++) begin
      arst_n       = 1'b0;
      random_wait  = (ph == 1);
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n       = 1'b1;
      phase_active = 1'b1;
      while (!phase_done) @(posedge clk);
      phase_active = 1'b0;
      @(negedge clk);
    end
    if (errors == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "check failures");
    end
  end

endmodule

/* src.f */
design/rv32i_pkg.sv
design/rv32i_decode.sv
design/rv32i_regfile.sv
design/rv32i_pipe_reg.sv
design/rv32i_execute.sv
design/rv32i_hazard.sv
design/rv32i_core.sv
dv/rv32i_core_checker.sv
dv/rv32i_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module rv32i_core_tb -f src.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
